/* common/simple_system_pkg.sv */
// Shared bus types, host and device indices and the address map.
// Every device occupies a naturally aligned power-of-two range.
package simple_system_pkg;

  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;
  localparam int BeWidth   = DataWidth / 8;

  localparam int NrHosts   = 2;
  localparam int NrDevices = 3;

  // Lower host index wins arbitration
  localparam int HostData  = 0;
  localparam int HostInstr = 1;

  localparam int DevRam     = 0;
  localparam int DevSimCtrl = 1;
  localparam int DevTimer   = 2;

  // Address map, indexed by device
  localparam logic [AddrWidth-1:0] DevAddrBase [NrDevices] = '{
    32'h0010_0000,
    32'h0002_0000,
    32'h0003_0000
  };
  localparam logic [AddrWidth-1:0] DevAddrMask [NrDevices] = '{
    ~32'h000F_FFFF,
    ~32'h0000_03FF,
    ~32'h0000_03FF
  };

  // Register offsets inside the 1 kB control windows
  localparam int RegOffsetWidth = 10;

  localparam logic [RegOffsetWidth-1:0] SimCharOffset = 10'h000;
  localparam logic [RegOffsetWidth-1:0] SimHaltOffset = 10'h008;

  localparam logic [RegOffsetWidth-1:0] MtimeLoOffset    = 10'h000;
  localparam logic [RegOffsetWidth-1:0] MtimeHiOffset    = 10'h004;
  localparam logic [RegOffsetWidth-1:0] MtimecmpLoOffset = 10'h008;
  localparam logic [RegOffsetWidth-1:0] MtimecmpHiOffset = 10'h00C;

  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [BeWidth-1:0]   be;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  // gnt is only ever set by the bus toward a host
  typedef struct packed {
    logic                 gnt;
    logic                 rvalid;
    logic                 err;
    logic [DataWidth-1:0] rdata;
  } bus_rsp_t;

  // Byte-enable merge of a write into an existing word
  function automatic logic [DataWidth-1:0] apply_be(
    input logic [DataWidth-1:0] old_data,
    input logic [DataWidth-1:0] new_data,
    input logic [BeWidth-1:0]   be
  );
    logic [DataWidth-1:0] merged;
    merged = old_data;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = new_data[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

/* src/bus/bus_xbar.sv */
// Fixed-priority bus: one grant per cycle, lowest host index first.
// Devices must answer exactly one cycle after accepting a request.
`timescale 1ns/100ps

module bus_xbar (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  simple_system_pkg::bus_req_t  host_req_i [simple_system_pkg::NrHosts],
  input  simple_system_pkg::bus_rsp_t  dev_rsp_i  [simple_system_pkg::NrDevices],
  output simple_system_pkg::bus_rsp_t  host_rsp_o [simple_system_pkg::NrHosts],
  output simple_system_pkg::bus_req_t  dev_req_o  [simple_system_pkg::NrDevices]
);

  localparam int NrHosts   = simple_system_pkg::NrHosts;
  localparam int NrDevices = simple_system_pkg::NrDevices;
  localparam int HostIdxW  = $clog2(NrHosts);
  localparam int DevIdxW   = $clog2(NrDevices);

  logic                gnt_valid;
  logic [HostIdxW-1:0] gnt_idx;
  logic [NrDevices-1:0] dev_match;
  logic                dev_hit;
  logic [DevIdxW-1:0]  dev_idx;
  logic [NrDevices-1:0] dev_req_vec;

  // State of the transaction answered in the next cycle
  logic                rsp_pending_q;
  logic                rsp_unmapped_q;
  logic [HostIdxW-1:0] rsp_host_q;
  logic [DevIdxW-1:0]  rsp_dev_q;
  logic                rsp_valid;

  // Scan downward so the lowest requesting index wins
  always_comb begin
    gnt_valid = 1'b0;
    gnt_idx   = '0;
    for (int h = NrHosts - 1; h >= 0; h--) begin
      if (host_req_i[h].req) begin
        gnt_valid = 1'b1;
        gnt_idx   = HostIdxW'(h);
      end
    end
  end

  // Address decode of the winning host
  always_comb begin
    dev_idx = '0;
    for (int d = 0; d < NrDevices; d++) begin
      dev_match[d] = ((host_req_i[gnt_idx].addr & simple_system_pkg::DevAddrMask[d]) ==
                      simple_system_pkg::DevAddrBase[d]);
      if (dev_match[d]) begin
        dev_idx = DevIdxW'(d);
      end
    end
  end

  assign dev_hit = |dev_match;

  // Payload goes to every device, only the matching one sees req
  always_comb begin
    for (int d = 0; d < NrDevices; d++) begin
      dev_req_o[d]     = host_req_i[gnt_idx];
      dev_req_o[d].req = gnt_valid & dev_match[d];
      dev_req_vec[d]   = dev_req_o[d].req;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_pending_q  <= 1'b0;
      rsp_unmapped_q <= 1'b0;
      rsp_host_q     <= '0;
      rsp_dev_q      <= '0;
    end else begin
      rsp_pending_q  <= gnt_valid;
      rsp_unmapped_q <= gnt_valid & ~dev_hit;
      rsp_host_q     <= gnt_idx;
      rsp_dev_q      <= dev_idx;
    end
  end

  // Unmapped accesses are answered locally
  assign rsp_valid = rsp_pending_q & (rsp_unmapped_q | dev_rsp_i[rsp_dev_q].rvalid);

  always_comb begin
    for (int h = 0; h < NrHosts; h++) begin
      host_rsp_o[h].gnt    = gnt_valid & (gnt_idx == HostIdxW'(h));
      host_rsp_o[h].rvalid = rsp_valid & (rsp_host_q == HostIdxW'(h));
      host_rsp_o[h].err    = host_rsp_o[h].rvalid &
                             (rsp_unmapped_q | dev_rsp_i[rsp_dev_q].err);
      host_rsp_o[h].rdata  = (host_rsp_o[h].rvalid && !rsp_unmapped_q) ?
                             dev_rsp_i[rsp_dev_q].rdata : '0;
    end
  end

  // Overlapping address ranges would select two devices
  a_one_dev_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(dev_req_vec));

  for (genvar h = 0; h < NrHosts; h++) begin : g_host_chk
    a_gnt_then_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      host_rsp_o[h].gnt |=> host_rsp_o[h].rvalid);
  end

endmodule

/* src/ram_1p.sv */
// Word-organised RAM, read data one cycle after the request.
// Only the word index inside the RAM window is decoded.
`timescale 1ns/100ps

module ram_1p #(
  parameter int Depth = 262144
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  simple_system_pkg::bus_req_t req_i,
  output simple_system_pkg::bus_rsp_t rsp_o
);

  localparam int AW       = simple_system_pkg::AddrWidth;
  localparam int DW       = simple_system_pkg::DataWidth;
  localparam int IdxWidth = $clog2(Depth);

  logic [DW-1:0]       mem [Depth];
  logic [AW-1:0]       offset;
  logic [AW-3:0]       word_idx;
  logic [IdxWidth-1:0] mem_idx;
  logic                rvalid_q;
  logic [DW-1:0]       rdata_q;

  assign offset   = req_i.addr & ~simple_system_pkg::DevAddrMask[simple_system_pkg::DevRam];
  assign word_idx = offset[AW-1:2];
  assign mem_idx  = word_idx[IdxWidth-1:0];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        mem[mem_idx] <= simple_system_pkg::apply_be(mem[mem_idx], req_i.wdata, req_i.be);
        rdata_q      <= '0;
      end else begin
        rdata_q <= mem[mem_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o.gnt    = 1'b0;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.err    = 1'b0;
  assign rsp_o.rdata  = rdata_q;

  // Upper address bits inside the window must not alias
  a_idx_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.req |-> (word_idx < Depth));

endmodule

/* src/sim_ctrl.sv */
// Simulation control: character output and a halt flag.
// Halt is sticky until reset; reads always return zero.
`timescale 1ns/100ps

module sim_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  simple_system_pkg::bus_req_t req_i,
  output simple_system_pkg::bus_rsp_t rsp_o,
  output logic                        char_valid_o,
  output logic [7:0]                  char_o,
  output logic                        halt_o
);

  logic [simple_system_pkg::RegOffsetWidth-1:0] offset;
  logic       is_char;
  logic       is_halt;
  logic       wr_char;
  logic       wr_halt;
  logic       bad_offset;
  logic       char_valid_q;
  logic [7:0] char_q;
  logic       halt_q;
  logic       rvalid_q;
  logic       err_q;

  assign offset  = req_i.addr[simple_system_pkg::RegOffsetWidth-1:0];
  assign is_char = (offset == simple_system_pkg::SimCharOffset);
  assign is_halt = (offset == simple_system_pkg::SimHaltOffset);

  // Character only goes out when its byte lane is written
  assign wr_char    = req_i.req & req_i.we & is_char & req_i.be[0];
  assign wr_halt    = req_i.req & req_i.we & is_halt;
  assign bad_offset = req_i.req & ~(is_char | is_halt);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      char_valid_q <= 1'b0;
      halt_q       <= 1'b0;
      rvalid_q     <= 1'b0;
      err_q        <= 1'b0;
    end else begin
      char_valid_q <= wr_char;
      halt_q       <= halt_q | wr_halt;
      rvalid_q     <= req_i.req;
      err_q        <= bad_offset;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_char) begin
      char_q <= req_i.wdata[7:0];
    end
  end

  assign char_valid_o = char_valid_q;
  assign char_o       = char_q;
  assign halt_o       = halt_q;

  assign rsp_o.gnt    = 1'b0;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.err    = err_q;
  assign rsp_o.rdata  = '0;

endmodule

/* src/timer/timer.sv */
// Machine timer with 64-bit mtime and mtimecmp, accessed as 32-bit halves.
// A write to an mtime half suspends the increment for that cycle.
`timescale 1ns/100ps

module timer (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  simple_system_pkg::bus_req_t req_i,
  output simple_system_pkg::bus_rsp_t rsp_o,
  output logic                        timer_irq_o
);

  localparam int DW = simple_system_pkg::DataWidth;

  logic [simple_system_pkg::RegOffsetWidth-1:0] offset;
  logic [63:0]   mtime_q;
  logic [63:0]   mtime_d;
  logic [63:0]   mtimecmp_q;
  logic [63:0]   mtimecmp_d;
  logic [DW-1:0] rdata_d;
  logic [DW-1:0] rdata_q;
  logic          err_d;
  logic          err_q;
  logic          rvalid_q;
  logic          irq_q;

  assign offset = req_i.addr[simple_system_pkg::RegOffsetWidth-1:0];

  always_comb begin
    mtime_d    = mtime_q + 64'd1;
    mtimecmp_d = mtimecmp_q;
    rdata_d    = '0;
    err_d      = 1'b0;
    if (req_i.req) begin
      case (offset)
        simple_system_pkg::MtimeLoOffset: begin
          if (req_i.we) begin
            mtime_d = {mtime_q[63:32],
                       simple_system_pkg::apply_be(mtime_q[31:0], req_i.wdata, req_i.be)};
          end else begin
            rdata_d = mtime_q[31:0];
          end
        end
        simple_system_pkg::MtimeHiOffset: begin
          if (req_i.we) begin
            mtime_d = {simple_system_pkg::apply_be(mtime_q[63:32], req_i.wdata, req_i.be),
                       mtime_q[31:0]};
          end else begin
            rdata_d = mtime_q[63:32];
          end
        end
        simple_system_pkg::MtimecmpLoOffset: begin
          if (req_i.we) begin
            mtimecmp_d[31:0] = simple_system_pkg::apply_be(mtimecmp_q[31:0], req_i.wdata,
                                                           req_i.be);
          end else begin
            rdata_d = mtimecmp_q[31:0];
          end
        end
        simple_system_pkg::MtimecmpHiOffset: begin
          if (req_i.we) begin
            mtimecmp_d[63:32] = simple_system_pkg::apply_be(mtimecmp_q[63:32], req_i.wdata,
                                                            req_i.be);
          end else begin
            rdata_d = mtimecmp_q[63:32];
          end
        end
        default: err_d = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      irq_q      <= 1'b0;
      rvalid_q   <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      irq_q      <= (mtime_q >= mtimecmp_q);
      rvalid_q   <= req_i.req;
      err_q      <= err_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  assign timer_irq_o  = irq_q;
  assign rsp_o.gnt    = 1'b0;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.err    = err_q;
  assign rsp_o.rdata  = rdata_q;

endmodule

/* src/simple_system.sv */
// Two bus hosts (data and instruction ports) sharing RAM, sim control and timer.
// The instruction port is read-only, full-word.
`timescale 1ns/100ps

module simple_system #(
  parameter int RamDepth = 262144
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  simple_system_pkg::bus_req_t data_req_i,
  output simple_system_pkg::bus_rsp_t data_rsp_o,
  input  logic                        instr_req_i,
  input  logic [31:0]                 instr_addr_i,
  output simple_system_pkg::bus_rsp_t instr_rsp_o,
  output logic                        char_valid_o,
  output logic [7:0]                  char_o,
  output logic                        halt_o,
  output logic                        timer_irq_o
);

  simple_system_pkg::bus_req_t host_req [simple_system_pkg::NrHosts];
  simple_system_pkg::bus_rsp_t host_rsp [simple_system_pkg::NrHosts];
  simple_system_pkg::bus_req_t dev_req  [simple_system_pkg::NrDevices];
  simple_system_pkg::bus_rsp_t dev_rsp  [simple_system_pkg::NrDevices];

  assign host_req[simple_system_pkg::HostData] = data_req_i;

  // Instruction fetch never writes
  assign host_req[simple_system_pkg::HostInstr].req   = instr_req_i;
  assign host_req[simple_system_pkg::HostInstr].we    = 1'b0;
  assign host_req[simple_system_pkg::HostInstr].be    = '1;
  assign host_req[simple_system_pkg::HostInstr].addr  = instr_addr_i;
  assign host_req[simple_system_pkg::HostInstr].wdata = '0;

  assign data_rsp_o  = host_rsp[simple_system_pkg::HostData];
  assign instr_rsp_o = host_rsp[simple_system_pkg::HostInstr];

  bus_xbar u_bus (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .host_req_i (host_req),
    .dev_rsp_i  (dev_rsp),
    .host_rsp_o (host_rsp),
    .dev_req_o  (dev_req)
  );

  ram_1p #(
    .Depth (RamDepth)
  ) u_ram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (dev_req[simple_system_pkg::DevRam]),
    .rsp_o   (dev_rsp[simple_system_pkg::DevRam])
  );

  sim_ctrl u_sim_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (dev_req[simple_system_pkg::DevSimCtrl]),
    .rsp_o        (dev_rsp[simple_system_pkg::DevSimCtrl]),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

  timer u_timer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (dev_req[simple_system_pkg::DevTimer]),
    .rsp_o       (dev_rsp[simple_system_pkg::DevTimer]),
    .timer_irq_o (timer_irq_o)
  );

endmodule

/* tb/tb_simple_system.sv */
// Testbench acting as the core on both host ports of simple_system.
// Reads tb/simple_system_input.txt, so it must run from the project root.
`timescale 1ns/100ps

module tb_simple_system;

  localparam int HostData   = simple_system_pkg::HostData;
  localparam int HostInstr  = simple_system_pkg::HostInstr;
  localparam int GntTimeout = 20;
  localparam int RspTimeout = 20;
  localparam int EvtTimeout = 20;
  localparam int RandWindow = 256;
  localparam int SelIrq     = 0;
  localparam int SelHalt    = 1;
  localparam int SelChar    = 2;

  logic                        clk;
  logic                        rst_n;
  simple_system_pkg::bus_req_t data_req;
  simple_system_pkg::bus_rsp_t data_rsp;
  logic                        instr_req;
  logic [31:0]                 instr_addr;
  simple_system_pkg::bus_rsp_t instr_rsp;
  logic                        char_valid;
  logic [7:0]                  char_out;
  logic                        halt;
  logic                        timer_irq;

  int          cyc;
  int          rec_num;
  logic [31:0] arb_addr;
  logic [31:0] arb_exp;
  logic [7:0]  char_seen [$];
  logic [31:0] ram_model [int];

  // 4 kB of RAM covers every address in the stimulus file
  simple_system #(
    .RamDepth (1024)
  ) DUT (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .data_req_i   (data_req),
    .data_rsp_o   (data_rsp),
    .instr_req_i  (instr_req),
    .instr_addr_i (instr_addr),
    .instr_rsp_o  (instr_rsp),
    .char_valid_o (char_valid),
    .char_o       (char_out),
    .halt_o       (halt),
    .timer_irq_o  (timer_irq)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // One entry per cycle with char_valid_o high
  always @(negedge clk) begin
    if (rst_n && char_valid) begin
      char_seen.push_back(char_out);
    end
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      fail_run($sformatf("FAILED %s expected %h actual %h in record %0d",
                         name, exp, act, rec_num));
    end
  endtask

  function automatic simple_system_pkg::bus_rsp_t rsp_of(input int host);
    if (host == HostData) begin
      return data_rsp;
    end
    return instr_rsp;
  endfunction

  function automatic string port_of(input int host);
    return (host == HostData) ? "data_rsp_o" : "instr_rsp_o";
  endfunction

  function automatic logic watched_level(input int sel);
    case (sel)
      SelIrq:  return timer_irq;
      SelHalt: return halt;
      default: return char_seen.size() != 0;
    endcase
  endfunction

  // Reference merge of enabled byte lanes
  function automatic logic [31:0] byte_merge(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic drive_req(input int host, input logic we, input logic [3:0] be,
                           input logic [31:0] addr, input logic [31:0] wdata);
    if (host == HostData) begin
      data_req.req   <= 1'b1;
      data_req.we    <= we;
      data_req.be    <= be;
      data_req.addr  <= addr;
      data_req.wdata <= wdata;
    end else begin
      instr_req  <= 1'b1;
      instr_addr <= addr;
    end
  endtask

  task automatic drop_req(input int host);
    if (host == HostData) begin
      data_req <= '0;
    end else begin
      instr_req <= 1'b0;
    end
  endtask

  task automatic wait_grant(input int host, output int grant_cyc);
    simple_system_pkg::bus_rsp_t rsp;
    int cnt;
    cnt = 0;
    @(negedge clk);
    rsp = rsp_of(host);
    while (!rsp.gnt && cnt < GntTimeout) begin
      cnt++;
      @(negedge clk);
      rsp = rsp_of(host);
    end
    assert (rsp.gnt) else begin
      fail_run($sformatf("Timed out waiting for a grant on %s", port_of(host)));
    end
    // Grant is taken at the next rising edge
    grant_cyc = cyc + 1;
  endtask

  task automatic wait_rvalid(input int host, output logic [31:0] rdata, output logic err);
    simple_system_pkg::bus_rsp_t rsp;
    int cnt;
    cnt = 0;
    @(negedge clk);
    rsp = rsp_of(host);
    while (!rsp.rvalid && cnt < RspTimeout) begin
      cnt++;
      @(negedge clk);
      rsp = rsp_of(host);
    end
    assert (rsp.rvalid) else begin
      fail_run($sformatf("Timed out waiting for rvalid on %s", port_of(host)));
    end
    check_value({port_of(host), ".rvalid cycles after grant"}, 32'd1, 32'(cnt + 1));
    rdata = rsp.rdata;
    err   = rsp.err;
  endtask

  task automatic bus_access(input int host, input logic we, input logic [3:0] be,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err,
                            output int grant_cyc);
    @(posedge clk);
    drive_req(host, we, be, addr, wdata);
    wait_grant(host, grant_cyc);
    @(posedge clk);
    drop_req(host);
    wait_rvalid(host, rdata, err);
  endtask

  task automatic checked_access(input int host, input logic we, input logic [3:0] be,
                                input logic [31:0] addr, input logic [31:0] wdata,
                                input logic [31:0] exp_data, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    int          grant_cyc;
    bus_access(host, we, be, addr, wdata, rdata, err, grant_cyc);
    check_value({port_of(host), ".err"}, 32'(exp_err), 32'(err));
    check_value({port_of(host), ".rdata"}, exp_data, rdata);
  endtask

  task automatic wait_for_level(input string name, input int sel, input logic level,
                                input int bound);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (watched_level(sel) !== level && cnt < bound) begin
      cnt++;
      @(negedge clk);
    end
    assert (watched_level(sel) === level) else begin
      fail_run($sformatf("Timed out after %0d cycles waiting for %s to become %0d",
                         bound, name, level));
    end
  endtask

  // Data host is granted first, instruction host one cycle later
  task automatic run_arbitration(input logic [31:0] data_addr, input logic [31:0] data_exp,
                                 input logic [31:0] fetch_addr, input logic [31:0] fetch_exp);
    logic [31:0] rdata;
    logic        err;
    @(posedge clk);
    drive_req(HostData, 1'b0, 4'hf, data_addr, '0);
    drive_req(HostInstr, 1'b0, 4'hf, fetch_addr, '0);
    @(negedge clk);
    check_value("data_rsp_o.gnt", 32'd1, 32'(data_rsp.gnt));
    check_value("instr_rsp_o.gnt", 32'd0, 32'(instr_rsp.gnt));
    @(posedge clk);
    drop_req(HostData);
    wait_rvalid(HostData, rdata, err);
    check_value("data_rsp_o.err", 32'd0, 32'(err));
    check_value("data_rsp_o.rdata", data_exp, rdata);
    check_value("instr_rsp_o.gnt", 32'd1, 32'(instr_rsp.gnt));
    @(posedge clk);
    drop_req(HostInstr);
    wait_rvalid(HostInstr, rdata, err);
    check_value("instr_rsp_o.err", 32'd0, 32'(err));
    check_value("instr_rsp_o.rdata", fetch_exp, rdata);
  endtask

  task automatic run_mtime_delta(input logic [31:0] addr, input int idle, input int exp_gap);
    logic [31:0] first;
    logic [31:0] second;
    logic        err;
    int          g1;
    int          g2;
    bus_access(HostData, 1'b0, 4'hf, addr, '0, first, err, g1);
    check_value("data_rsp_o.err", 32'd0, 32'(err));
    repeat (idle) @(posedge clk);
    bus_access(HostData, 1'b0, 4'hf, addr, '0, second, err, g2);
    check_value("data_rsp_o.err", 32'd0, 32'(err));
    check_value("grant gap in cycles", 32'(exp_gap), 32'(g2 - g1));
    check_value("mtime_lo difference", 32'(exp_gap), second - first);
  endtask

  task automatic run_mtimecmp_irq(input logic [31:0] base, input logic [31:0] k,
                                  input int bound);
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] now_lo;
    logic [63:0] target;
    logic        err;
    int          g;
    bus_access(HostData, 1'b0, 4'hf, base + 32'(simple_system_pkg::MtimeLoOffset), '0,
               lo, err, g);
    check_value("data_rsp_o.err", 32'd0, 32'(err));
    bus_access(HostData, 1'b0, 4'hf, base + 32'(simple_system_pkg::MtimeHiOffset), '0,
               hi, err, g);
    check_value("data_rsp_o.err", 32'd0, 32'(err));
    target = {hi, lo} + 64'(k);
    checked_access(HostData, 1'b1, 4'hf, base + 32'(simple_system_pkg::MtimecmpHiOffset),
                   target[63:32], '0, 1'b0);
    check_value("timer_irq_o", 32'd0, 32'(timer_irq));
    checked_access(HostData, 1'b1, 4'hf, base + 32'(simple_system_pkg::MtimecmpLoOffset),
                   target[31:0], '0, 1'b0);
    wait_for_level("timer_irq_o", SelIrq, 1'b1, bound);
    bus_access(HostData, 1'b0, 4'hf, base + 32'(simple_system_pkg::MtimeLoOffset), '0,
               now_lo, err, g);
    assert (now_lo >= target[31:0]) else begin
      fail_run($sformatf("FAILED mtime_lo %h is below mtimecmp %h while timer_irq_o is set",
                         now_lo, target[31:0]));
    end
  endtask

  task automatic run_random(input logic [31:0] base, input int count);
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    int          idx;
    for (int i = 0; i < count; i++) begin
      idx  = $urandom_range(RandWindow - 1, 0);
      addr = base + 32'(idx) * 4;
      // Fill a fresh word completely before merging into it
      if (!ram_model.exists(idx)) begin
        wdata = $urandom();
        checked_access(HostData, 1'b1, 4'hf, addr, wdata, '0, 1'b0);
        ram_model[idx] = wdata;
      end
      wdata = $urandom();
      be    = 4'($urandom());
      checked_access(HostData, 1'b1, be, addr, wdata, '0, 1'b0);
      ram_model[idx] = byte_merge(ram_model[idx], wdata, be);
      checked_access(HostData, 1'b0, 4'hf, addr, '0, ram_model[idx], 1'b0);
    end
  endtask

  task automatic run_record(input logic [7:0] op, input int host, input logic [31:0] addr,
                            input logic [3:0] be, input logic [31:0] wdata,
                            input logic [31:0] exp, input logic exp_err);
    case (op)
      "W": checked_access(host, 1'b1, be, addr, wdata, exp, exp_err);
      "R": checked_access(host, 1'b0, be, addr, wdata, exp, exp_err);
      "A": begin
        if (host == HostInstr) begin
          arb_addr = addr;
          arb_exp  = exp;
        end else begin
          run_arbitration(addr, exp, arb_addr, arb_exp);
        end
      end
      "T": run_mtime_delta(addr, int'(wdata), int'(exp));
      "I": run_mtimecmp_irq(addr, wdata, int'(exp));
      "Q": wait_for_level("timer_irq_o", SelIrq, exp[0], int'(wdata));
      "C": begin
        checked_access(host, 1'b1, be, addr, wdata, '0, exp_err);
        wait_for_level("char_valid_o", SelChar, 1'b1, EvtTimeout);
        check_value("char_o", exp, 32'(char_seen.pop_front()));
      end
      "H": begin
        // Nothing before this write may have set the flag
        check_value("halt_o", 32'd0, 32'(halt));
        checked_access(host, 1'b1, be, addr, wdata, '0, exp_err);
        wait_for_level("halt_o", SelHalt, 1'b1, EvtTimeout);
      end
      "X": run_random(addr, int'(wdata));
      default: fail_run($sformatf("Unknown operation %c in record %0d", op, rec_num));
    endcase
  endtask

  initial begin
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] host;
    logic [31:0] addr;
    logic [31:0] be;
    logic [31:0] wdata;
    logic [31:0] exp;
    logic [31:0] exp_err;
    void'($urandom(32'hdbed_46e2));
    clk        = 1'b0;
    rst_n      = 1'b0;
    data_req   = '0;
    instr_req  = 1'b0;
    instr_addr = '0;
    cyc        = 0;
    rec_num    = 0;
    arb_addr   = '0;
    arb_exp    = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("data_rsp_o gnt rvalid err", 32'd0,
                32'({data_rsp.gnt, data_rsp.rvalid, data_rsp.err}));
    check_value("instr_rsp_o gnt rvalid err", 32'd0,
                32'({instr_rsp.gnt, instr_rsp.rvalid, instr_rsp.err}));
    check_value("char_valid_o halt_o timer_irq_o", 32'd0,
                32'({char_valid, halt, timer_irq}));
    fd = $fopen("tb/simple_system_input.txt", "r");
    assert (fd != 0) else begin
      fail_run("Could not open the stimulus file tb/simple_system_input.txt");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
        rec_num++;
        n = $sscanf(line, "%c %h %h %h %h %h %h", op, host, addr, be, wdata, exp, exp_err);
        assert (n == 7) else begin
          fail_run($sformatf("Record %0d of the stimulus file is malformed", rec_num));
        end
        run_record(op, int'(host), addr, be[3:0], wdata, exp, exp_err[0]);
      end
    end
    $fclose(fd);
    check_value("char_valid_o pulses left over", 32'd0, 32'(char_seen.size()));
    check_value("halt_o", 32'd1, 32'(halt));
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* simple_system.f */
common/simple_system_pkg.sv
src/bus/bus_xbar.sv
src/ram_1p.sv
src/sim_ctrl.sv
src/timer/timer.sv
src/simple_system.sv
tb/tb_simple_system.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_simple_system
FILELIST  := simple_system.f
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))
STIMULUS  := tb/simple_system_input.txt

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(STIMULUS)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* tb/simple_system_input.txt */
# Columns: op host addr be wdata exp err, every field after op in hex
# Ops: W/R bus access, A arbitration pair, T mtime gap, I irq set, Q irq level, C char, H halt, X random
R 0 00030008 f 00000000 ffffffff 0
R 0 0003000c f 00000000 ffffffff 0
W 0 00100000 f 11223344 00000000 0
W 0 00100000 3 aabbccdd 00000000 0
W 0 00100000 8 99000000 00000000 0
R 0 00100000 f 00000000 9922ccdd 0
R 1 00100000 f 00000000 9922ccdd 0
W 0 00100004 f 00000000 00000000 0
W 0 00100004 6 12345678 00000000 0
W 0 00100004 1 000000ef 00000000 0
R 1 00100004 f 00000000 003456ef 0
R 0 00100004 f 00000000 003456ef 0
W 0 00100ffc f deadbeef 00000000 0
W 0 00100ffc c 55550000 00000000 0
R 1 00100ffc f 00000000 5555beef 0
# Unmapped addresses and bad register offsets
R 0 00050000 f 00000000 00000000 1
R 1 00000000 f 00000000 00000000 1
W 0 00200000 f 12345678 00000000 1
R 0 00030010 f 00000000 00000000 1
W 0 00020004 1 00000041 00000000 1
# Both hosts in one cycle, instruction record first
W 0 00100010 f cafef00d 00000000 0
W 0 00100014 f 0badc0de 00000000 0
A 1 00100014 f 00000000 0badc0de 0
A 0 00100010 f 00000000 cafef00d 0
# Timer: idle cycles in wdata, grant gap in exp
T 0 00030000 f 00000005 00000007 0
T 0 00030000 f 00000000 00000002 0
I 0 00030000 f 00000014 00000028 0
W 0 00030008 f ffffffff 00000000 0
W 0 0003000c f ffffffff 00000000 0
Q 0 00000000 0 00000008 00000000 0
R 0 00030008 f 00000000 ffffffff 0
# Character output, then halt
C 0 00020000 1 00000048 00000048 0
C 0 00020000 f 00000069 00000069 0
C 0 00020000 1 00000a21 00000021 0
W 0 00020000 2 00005800 00000000 0
H 0 00020008 f 00000001 00000000 0
R 0 00020000 f 00000000 00000000 0
X 0 00100400 0 00000040 00000000 0
